/* src/if_pkg.sv */
// Types and sizes shared by the fetch stage
// Only 32-bit instructions are supported, so sequential fetch steps by 4
// Queue depth and outstanding limit are fixed here and nowhere else
package if_pkg;

  //////////////////////
  // Sizes
  //////////////////////

  // Entries in the fetch queue
  localparam int unsigned FIFO_DEPTH      = 3;
  // Width of the queue count, holds 0 to FIFO_DEPTH
  localparam int unsigned FIFO_CNT_W      = 2;
  // Reads that may be granted but not yet answered
  localparam int unsigned MAX_OUTSTANDING = 2;

  //////////////////////
  // Vector types
  //////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // Trap vector base, used as {base, 7'b0}
  typedef logic [24:0] mtvec_base_t;
  typedef logic [4:0]  irq_idx_t;

  // Redirect target select from the core controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Fetch FSM states
  typedef enum logic [1:0] {
    FETCH_IDLE  = 2'd0,
    FETCH_RUN   = 2'd1,
    FETCH_FLUSH = 2'd2
  } fetch_state_e;

  //////////////////////
  // Bundles
  //////////////////////

  // Controller command, 11 bits
  typedef struct packed {
    logic     pc_set;
    pc_mux_e  pc_mux;
    irq_idx_t irq_idx;
    logic     halt_if;
    logic     kill_if;
  } ctrl_fsm_t;

  // Redirect sources, 153 bits
  typedef struct packed {
    addr_t       boot_addr;
    addr_t       jump_target;
    addr_t       branch_target;
    addr_t       mepc;
    mtvec_base_t mtvec_base;
  } targets_t;

  // One fetched word with its address, 65 bits
  typedef struct packed {
    addr_t  addr;
    instr_t rdata;
    logic   err;
  } fetch_entry_t;

  // IF/ID register contents, 68 bits
  typedef struct packed {
    logic   instr_valid;
    addr_t  pc;
    instr_t instr;
    logic   bus_err;
    logic   trigger_match;
    logic   abort_op;
  } if_id_pipe_t;

endpackage

/* src/pc_select.sv */
// Redirect target selection, purely combinational
// Every target leaves here word aligned
`timescale 1ns/1ps

module pc_select (
  input  if_pkg::ctrl_fsm_t ctrl_fsm_i,
  input  if_pkg::targets_t  targets_i,
  output if_pkg::addr_t     branch_addr_o,
  output logic              csr_mtvec_init_o
);

  // Target mux
  always_comb begin
    // Fall back to boot for unused encodings
    branch_addr_o = {targets_i.boot_addr[31:2], 2'b00};

    unique case (ctrl_fsm_i.pc_mux)
      if_pkg::PC_BOOT: begin
        branch_addr_o = {targets_i.boot_addr[31:2], 2'b00};
      end
      if_pkg::PC_JUMP: begin
        branch_addr_o = {targets_i.jump_target[31:2], 2'b00};
      end
      if_pkg::PC_BRANCH: begin
        branch_addr_o = {targets_i.branch_target[31:2], 2'b00};
      end
      // Return from trap
      if_pkg::PC_MRET: begin
        branch_addr_o = {targets_i.mepc[31:2], 2'b00};
      end
      // All exceptions share the trap base
      if_pkg::PC_TRAP_EXC: begin
        branch_addr_o = {targets_i.mtvec_base, 7'h00};
      end
      // Vectored interrupt, base plus 4 * index
      if_pkg::PC_TRAP_IRQ: begin
        branch_addr_o = {targets_i.mtvec_base, ctrl_fsm_i.irq_idx, 2'b00};
      end
      default: ;
    endcase
  end

  // Boot redirect also asks the CSR file to load mtvec
  assign csr_mtvec_init_o = ctrl_fsm_i.pc_set && (ctrl_fsm_i.pc_mux == if_pkg::PC_BOOT);

endmodule

/* src/fetch_ctrl.sv */
// Fetch FSM driving the request/grant/response instruction bus
// Up to MAX_OUTSTANDING reads in flight, responses must return in order
// A redirect may move the address of a request still waiting for grant
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            pc_set_i,
  input  if_pkg::addr_t                   branch_addr_i,
  input  logic [if_pkg::FIFO_CNT_W-1:0]   fifo_cnt_i,
  output logic                            instr_req_o,
  output if_pkg::addr_t                   instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  if_pkg::instr_t                  instr_rdata_i,
  input  logic                            instr_err_i,
  output logic                            push_o,
  output if_pkg::fetch_entry_t            push_entry_o,
  output logic                            flush_o,
  output logic                            busy_o
);

  if_pkg::fetch_state_e                state_q, state_d;
  if_pkg::addr_t                       fetch_addr_q;
  // Outstanding and discard counts fit in the queue count width
  logic [if_pkg::FIFO_CNT_W-1:0]       outst_q, outst_d;
  logic [if_pkg::FIFO_CNT_W-1:0]       discard_q, discard_d;
  logic [if_pkg::FIFO_CNT_W:0]         inflight_sum;
  // Granted addresses, paired with responses in order
  if_pkg::addr_t                       gnt_addr_q [if_pkg::MAX_OUTSTANDING];
  logic                                wr_ptr_q;
  logic                                rd_ptr_q;
  logic                                gnt_ok;

  //////////////////////
  // Request side
  //////////////////////

  // Words in the queue plus words on their way
  assign inflight_sum = {1'b0, fifo_cnt_i} + {1'b0, outst_q};

  assign instr_req_o  = (state_q != if_pkg::FETCH_IDLE) &&
                        (inflight_sum < if_pkg::FIFO_DEPTH) &&
                        (outst_q < if_pkg::MAX_OUTSTANDING);
  assign instr_addr_o = fetch_addr_q;
  assign gnt_ok       = instr_req_o && instr_gnt_i;

  // Response side
  // Stale words are dropped while in FLUSH and in the redirect cycle
  assign push_o             = instr_rvalid_i && (state_q == if_pkg::FETCH_RUN) && !pc_set_i;
  assign push_entry_o.addr  = gnt_addr_q[rd_ptr_q];
  assign push_entry_o.rdata = instr_rdata_i;
  assign push_entry_o.err   = instr_err_i;

  assign flush_o = pc_set_i;
  assign busy_o  = (outst_q != '0);

  // Outstanding count after this cycle
  always_comb begin
    outst_d = outst_q;
    if (gnt_ok && !instr_rvalid_i) begin
      outst_d = outst_q + 1'b1;
    end else if (!gnt_ok && instr_rvalid_i) begin
      outst_d = outst_q - 1'b1;
    end
  end

  // Next state, redirect loads the discard count with what is still in flight
  always_comb begin
    state_d   = state_q;
    discard_d = discard_q;
    if (pc_set_i) begin
      discard_d = outst_d;
      state_d   = (outst_d != '0) ? if_pkg::FETCH_FLUSH : if_pkg::FETCH_RUN;
    end else if ((state_q == if_pkg::FETCH_FLUSH) && instr_rvalid_i) begin
      discard_d = discard_q - 1'b1;
      // Last stale word gone
      if (discard_q == 1) begin
        state_d = if_pkg::FETCH_RUN;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= if_pkg::FETCH_IDLE;
      fetch_addr_q <= '0;
      outst_q      <= '0;
      discard_q    <= '0;
      wr_ptr_q     <= 1'b0;
      rd_ptr_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      outst_q   <= outst_d;
      discard_q <= discard_d;
      if (pc_set_i) begin
        fetch_addr_q <= branch_addr_i;
      end else if (gnt_ok) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      // Pointers keep moving across redirects so stale words stay paired
      if (gnt_ok) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (instr_rvalid_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  // Address store
  always_ff @(posedge clk) begin
    if (gnt_ok) begin
      gnt_addr_q[wr_ptr_q] <= instr_addr_o;
    end
  end

  //////////////////////
  // Checks
  //////////////////////

  // Queue pops and pushes never lower the request before its grant
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i && !pc_set_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("fetch request dropped or moved before grant");

  a_outst_max: assert property (@(posedge clk) disable iff (!rst_n)
    outst_q <= if_pkg::MAX_OUTSTANDING)
    else $error("too many outstanding reads");

  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (outst_q != '0))
    else $error("rvalid with no read outstanding");

endmodule

/* src/fetch_fifo.sv */
// Three-entry circular queue of fetched words
// Flush has priority over push and pop in the same cycle
`timescale 1ns/1ps

module fetch_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          push_i,
  input  if_pkg::fetch_entry_t          entry_i,
  input  logic                          pop_i,
  output if_pkg::fetch_entry_t          head_o,
  output logic                          valid_o,
  output logic [if_pkg::FIFO_CNT_W-1:0] cnt_o
);

  if_pkg::fetch_entry_t          mem_q [if_pkg::FIFO_DEPTH];
  logic [if_pkg::FIFO_CNT_W-1:0] wr_ptr_q;
  logic [if_pkg::FIFO_CNT_W-1:0] rd_ptr_q;
  logic [if_pkg::FIFO_CNT_W-1:0] cnt_q;

  // Pointer step with wrap at the depth
  function automatic logic [if_pkg::FIFO_CNT_W-1:0] ptr_inc(
    input logic [if_pkg::FIFO_CNT_W-1:0] ptr
  );
    ptr_inc = (ptr == if_pkg::FIFO_DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  assign head_o  = mem_q[rd_ptr_q];
  assign valid_o = (cnt_q != '0);
  assign cnt_o   = cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      unique case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // Relies on the request limit in fetch_ctrl
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> ((cnt_q < if_pkg::FIFO_DEPTH) || pop_i))
    else $error("push into full fetch queue");

  // Relies on the pop gating in if_id_reg
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (cnt_q != '0))
    else $error("pop from empty fetch queue");

endmodule

/* src/if_id_reg.sv */
// IF/ID pipeline register with stall, halt and kill
// Holds its contents while decode is not ready
// A redirect drops the held instruction at the same edge as the queue flush
`timescale 1ns/1ps

module if_id_reg (
  input  logic                 clk,
  input  logic                 rst_n,
  input  if_pkg::fetch_entry_t head_i,
  input  logic                 head_valid_i,
  input  if_pkg::ctrl_fsm_t    ctrl_fsm_i,
  input  logic                 trigger_match_i,
  input  logic                 id_ready_i,
  output logic                 pop_o,
  output logic                 if_valid_o,
  output if_pkg::if_id_pipe_t  if_id_pipe_o
);

  logic           transfer;
  logic           valid_q;
  if_pkg::addr_t  pc_q;
  if_pkg::instr_t instr_q;
  logic           bus_err_q;
  logic           trigger_q;
  logic           abort_q;

  // Head usable only when neither halted nor killed
  assign if_valid_o = head_valid_i && !ctrl_fsm_i.halt_if && !ctrl_fsm_i.kill_if;

  // Kill discards the head, otherwise it leaves when decode takes it
  assign pop_o = (head_valid_i && ctrl_fsm_i.kill_if) || (if_valid_o && id_ready_i);

  assign transfer = if_valid_o && id_ready_i && !ctrl_fsm_i.pc_set;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (ctrl_fsm_i.pc_set) begin
      valid_q <= 1'b0;
    end else if (transfer) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // Decode took the old one and nothing new arrived
      valid_q <= 1'b0;
    end
  end

  // Payload, loaded only on a transfer
  always_ff @(posedge clk) begin
    if (transfer) begin
      pc_q      <= head_i.addr;
      instr_q   <= head_i.rdata;
      bus_err_q <= head_i.err;
      trigger_q <= trigger_match_i;
      abort_q   <= head_i.err || trigger_match_i;
    end
  end

  assign if_id_pipe_o = '{
    instr_valid:   valid_q,
    pc:            pc_q,
    instr:         instr_q,
    bus_err:       bus_err_q,
    trigger_match: trigger_q,
    abort_op:      abort_q
  };

endmodule

/* src/if_stage.sv */
// Instruction fetch stage top, 32-bit instructions only
// Bus responses must come back in request order
`timescale 1ns/1ps

module if_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  if_pkg::targets_t    targets_i,
  input  logic                trigger_match_i,
  input  logic                id_ready_i,
  // Instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_err_i,
  // Towards decode and CSR file
  output if_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                if_valid_o,
  output logic                csr_mtvec_init_o,
  output logic                if_busy_o
);

  if_pkg::addr_t                 branch_addr;
  logic [if_pkg::FIFO_CNT_W-1:0] fifo_cnt;
  logic                          push;
  if_pkg::fetch_entry_t          push_entry;
  logic                          flush;
  if_pkg::fetch_entry_t          head;
  logic                          head_valid;
  logic                          pop;

  pc_select u_pc_select (
    .ctrl_fsm_i       (ctrl_fsm_i),
    .targets_i        (targets_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (ctrl_fsm_i.pc_set),
    .branch_addr_i  (branch_addr),
    .fifo_cnt_i     (fifo_cnt),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .flush_o        (flush),
    .busy_o         (if_busy_o)
  );

  fetch_fifo u_fetch_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush),
    .push_i  (push),
    .entry_i (push_entry),
    .pop_i   (pop),
    .head_o  (head),
    .valid_o (head_valid),
    .cnt_o   (fifo_cnt)
  );

  if_id_reg u_if_id_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .head_i          (head),
    .head_valid_i    (head_valid),
    .ctrl_fsm_i      (ctrl_fsm_i),
    .trigger_match_i (trigger_match_i),
    .id_ready_i      (id_ready_i),
    .pop_o           (pop),
    .if_valid_o      (if_valid_o),
    .if_id_pipe_o    (if_id_pipe_o)
  );

endmodule

/* test/tb_if_stage.sv */
// Testbench for the fetch stage, run from the project root
// Redirect scenarios come from test/if_stage_vectors.txt, all fields hex
// Bus model answers in order with random grant and response delays
`timescale 1ns/1ps

module tb_if_stage;

  // Vector layout, ten words per scenario
  localparam int VEC_W    = 10;
  localparam int MAX_VEC  = 64;
  localparam int F_MUX    = 0;
  localparam int F_BOOT   = 1;
  localparam int F_JUMP   = 2;
  localparam int F_BRANCH = 3;
  localparam int F_MEPC   = 4;
  localparam int F_MTVEC  = 5;
  localparam int F_IRQ    = 6;
  localparam int F_COUNT  = 7;
  localparam int F_TRIG   = 8;
  localparam int F_STALL  = 9;
  // Memory contents are the address with this pattern folded in
  localparam logic [31:0] RDATA_KEY = 32'hA5A5_0000;

  logic                clk;
  logic                rst_n;
  if_pkg::ctrl_fsm_t   ctrl_fsm;
  if_pkg::targets_t    targets;
  logic                trigger_match;
  logic                id_ready;
  logic                instr_req;
  if_pkg::addr_t       instr_addr;
  logic                instr_gnt;
  logic                instr_rvalid;
  if_pkg::instr_t      instr_rdata;
  logic                instr_err;
  if_pkg::if_id_pipe_t if_id_pipe;
  logic                if_valid;
  logic                csr_mtvec_init;
  logic                if_busy;

  logic [31:0]   vec_mem [0:VEC_W*MAX_VEC-1];
  int            num_vec;
  int            limit_cycles = 0;
  integer        seed = 40923;

  // Bus model state
  logic          acc_s;
  if_pkg::addr_t addr_s;
  if_pkg::addr_t resp_addr_q [$];
  int            resp_due_q [$];
  if_pkg::addr_t resp_addr;
  int            cyc;
  int            gnt_wait;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  if_stage UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm),
    .targets_i        (targets),
    .trigger_match_i  (trigger_match),
    .id_ready_i       (id_ready),
    .instr_req_o      (instr_req),
    .instr_addr_o     (instr_addr),
    .instr_gnt_i      (instr_gnt),
    .instr_rvalid_i   (instr_rvalid),
    .instr_rdata_i    (instr_rdata),
    .instr_err_i      (instr_err),
    .if_id_pipe_o     (if_id_pipe),
    .if_valid_o       (if_valid),
    .csr_mtvec_init_o (csr_mtvec_init),
    .if_busy_o        (if_busy)
  );

  //////////////////////
  // Helpers
  //////////////////////

  task automatic check_value(input logic [67:0] actual, input logic [67:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Uniform value in 0 .. n-1
  function automatic int rand_below(input int n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // Expected redirect target of scenario v
  function automatic logic [31:0] redirect_target(input int v);
    logic [31:0] base;
    base = {vec_mem[v*VEC_W+F_MTVEC][24:0], 7'b0};
    case (vec_mem[v*VEC_W+F_MUX])
      1:       redirect_target = vec_mem[v*VEC_W+F_JUMP] & ~32'h3;
      2:       redirect_target = vec_mem[v*VEC_W+F_BRANCH] & ~32'h3;
      3:       redirect_target = vec_mem[v*VEC_W+F_MEPC] & ~32'h3;
      4:       redirect_target = base;
      5:       redirect_target = base + 32'd4 * vec_mem[v*VEC_W+F_IRQ][4:0];
      default: redirect_target = vec_mem[v*VEC_W+F_BOOT] & ~32'h3;
    endcase
  endfunction

  //////////////////////
  // Bus memory model
  //////////////////////

  // Handshake sampled mid cycle, both sides settled
  always @(negedge clk) begin
    acc_s  = instr_req && instr_gnt;
    addr_s = instr_addr;
    // Busy while a granted read has not finished its response cycle
    if (rst_n) begin
      check_value(if_busy, (resp_addr_q.size() != 0) || instr_rvalid,
                  "if_busy with reads in flight");
    end
  end

  always @(posedge clk) begin
    #2;
    if (!rst_n) begin
      instr_gnt    = 1'b0;
      instr_rvalid = 1'b0;
      resp_addr_q.delete();
      resp_due_q.delete();
      gnt_wait     = 0;
      cyc          = 0;
    end else begin
      cyc++;
      // Granted at the last edge, answer 1 to 3 cycles after the grant cycle
      if (acc_s) begin
        resp_addr_q.push_back(addr_s);
        resp_due_q.push_back(cyc + rand_below(3));
        gnt_wait = rand_below(3);
      end
      if (gnt_wait == 0) begin
        instr_gnt = 1'b1;
      end else begin
        instr_gnt = 1'b0;
        gnt_wait--;
      end
      // In order, only the oldest read may answer
      if ((resp_addr_q.size() != 0) && (cyc >= resp_due_q[0])) begin
        resp_addr    = resp_addr_q.pop_front();
        void'(resp_due_q.pop_front());
        instr_rvalid = 1'b1;
        instr_rdata  = resp_addr ^ RDATA_KEY;
        instr_err    = resp_addr[12];
      end else begin
        instr_rvalid = 1'b0;
        instr_rdata  = '0;
        instr_err    = 1'b0;
      end
    end
  end

  //////////////////////
  // Scenario steps
  //////////////////////

  // pc_set for one cycle, then look at the first fetch address
  task automatic apply_redirect(input int v);
    logic [31:0] target;
    logic        is_boot;
    target  = redirect_target(v);
    is_boot = (vec_mem[v*VEC_W+F_MUX] == 0);
    @(posedge clk);
    #2;
    ctrl_fsm.pc_set          = 1'b1;
    ctrl_fsm.pc_mux          = if_pkg::pc_mux_e'(vec_mem[v*VEC_W+F_MUX][2:0]);
    ctrl_fsm.irq_idx         = vec_mem[v*VEC_W+F_IRQ][4:0];
    targets.boot_addr        = vec_mem[v*VEC_W+F_BOOT];
    targets.jump_target      = vec_mem[v*VEC_W+F_JUMP];
    targets.branch_target    = vec_mem[v*VEC_W+F_BRANCH];
    targets.mepc             = vec_mem[v*VEC_W+F_MEPC];
    targets.mtvec_base       = vec_mem[v*VEC_W+F_MTVEC][24:0];
    trigger_match            = vec_mem[v*VEC_W+F_TRIG][0];
    id_ready                 = 1'b1;
    @(negedge clk);
    check_value(csr_mtvec_init, is_boot, "mtvec init pulse with pc_set");
    @(posedge clk);
    #2;
    ctrl_fsm.pc_set = 1'b0;
    @(negedge clk);
    check_value(instr_addr, target, "fetch address after redirect");
    check_value(if_id_pipe.instr_valid, 1'b0, "IF/ID valid after redirect");
    // Queue was emptied at the redirect edge
    check_value(if_valid, 1'b0, "if_valid after redirect");
    check_value(csr_mtvec_init, 1'b0, "mtvec init after pc_set");
  endtask

  // Take count instructions from IF/ID under the stall pattern
  task automatic consume_stream(input int v);
    logic [31:0]         exp_pc;
    logic                trig;
    logic                was_stalled;
    logic                prev_ready;
    logic                prev_offer;
    int                  count;
    int                  period;
    int                  done;
    int                  k;
    if_pkg::if_id_pipe_t held;
    exp_pc      = redirect_target(v);
    trig        = vec_mem[v*VEC_W+F_TRIG][0];
    count       = vec_mem[v*VEC_W+F_COUNT];
    period      = vec_mem[v*VEC_W+F_STALL];
    was_stalled = 1'b0;
    // Cycle after the redirect was ready with an empty queue
    prev_ready  = 1'b1;
    prev_offer  = 1'b0;
    done        = 0;
    k           = 0;
    while (done < count) begin
      @(posedge clk);
      #2;
      // Ready for period cycles, then stalled for period cycles
      id_ready = (period == 0) || (((k / period) % 2) == 0);
      k++;
      @(negedge clk);
      if (was_stalled) begin
        check_value(if_id_pipe, held, "IF/ID contents held during stall");
      end
      // An offered head with decode ready loads at the next edge, else valid drops
      if (prev_ready) begin
        check_value(if_id_pipe.instr_valid, prev_offer, "IF/ID valid after a ready cycle");
      end
      if (if_id_pipe.instr_valid && id_ready) begin
        check_value(if_id_pipe.pc, exp_pc, "IF/ID pc");
        check_value(if_id_pipe.instr, exp_pc ^ RDATA_KEY, "IF/ID instr");
        check_value(if_id_pipe.bus_err, exp_pc[12], "IF/ID bus_err");
        check_value(if_id_pipe.trigger_match, trig, "IF/ID trigger_match");
        check_value(if_id_pipe.abort_op, exp_pc[12] | trig, "IF/ID abort_op");
        exp_pc = exp_pc + 32'd4;
        done++;
      end
      was_stalled = !id_ready;
      held        = if_id_pipe;
      prev_ready  = id_ready;
      prev_offer  = if_valid;
    end
  endtask

  //////////////////////
  // Main flow
  //////////////////////

  initial begin : main_flow
    int total;
    int v;
    rst_n         = 1'b0;
    ctrl_fsm      = '0;
    targets       = '0;
    trigger_match = 1'b0;
    id_ready      = 1'b0;
    instr_gnt     = 1'b0;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    instr_err     = 1'b0;
    acc_s         = 1'b0;
    addr_s        = '0;

    $readmemh("test/if_stage_vectors.txt", vec_mem);
    num_vec = 0;
    while ((num_vec < MAX_VEC) && !$isunknown(vec_mem[num_vec*VEC_W])) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("No scenarios could be read from test/if_stage_vectors.txt");
      $display("Simulation FAILED");
      $fatal(1, "Missing vector file");
    end

    // Time budget grows with the instructions to consume
    total = 0;
    for (v = 0; v < num_vec; v++) begin
      total += vec_mem[v*VEC_W+F_COUNT];
    end
    limit_cycles = 200 * total + 20 * num_vec + 40;

    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle until the first redirect
    repeat (3) begin
      @(negedge clk);
      check_value(instr_req, 1'b0, "instr_req after reset");
      check_value(if_id_pipe.instr_valid, 1'b0, "IF/ID valid after reset");
      check_value(if_valid, 1'b0, "if_valid after reset");
      check_value(if_busy, 1'b0, "if_busy after reset");
      check_value(csr_mtvec_init, 1'b0, "mtvec init after reset");
    end

    for (v = 0; v < num_vec; v++) begin
      apply_redirect(v);
      consume_stream(v);
    end

    @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("The run timed out after %0d cycles before all scenarios were done", limit_cycles);
    $display("Simulation FAILED");
    $fatal(1, "Timeout");
  end

endmodule

/* test/if_stage_vectors.txt */
// One redirect per line, every field hex
// mux boot jump branch mepc mtvec_base irq count trigger stall_period
0 00000082 00000000 00000000 00000000 0000000 00 08 0 0
1 00000082 00000400 00000000 00000000 0000040 00 06 0 3
2 00000082 00000400 00000FF4 00000000 0000040 00 08 0 0
3 00000082 00000400 00000FF4 00002002 0000040 00 05 1 0
4 00000082 00000400 00000FF4 00002002 0000040 00 04 0 2
5 00000082 00000400 00000FF4 00002002 0000040 0B 05 1 4
1 00000082 00003000 00000FF4 00002002 0000040 00 01 0 0
2 00000082 00003000 00000200 00002002 0000040 00 00 0 0
1 00000082 00000600 00000200 00002002 0000040 00 07 0 6
5 00000082 00000600 00000200 00002002 0000021 1F 06 0 0
0 00001FFF 00000600 00000200 00002002 0000021 00 06 1 5
3 00001FFF 00000600 00000200 00000FFA 0000021 00 0A 0 1
4 00001FFF 00000600 00000200 00000FFA 0000021 00 03 1 0
2 00001FFF 00000600 00000010 00000FFA 0000021 00 0C 0 0
5 00001FFF 00000600 00000010 00000FFA 0000040 03 00 0 0
1 00001FFF 00000FF0 00000010 00000FFA 0000040 03 09 1 4

/* compile.f */
src/if_pkg.sv
src/pc_select.sv
src/fetch_ctrl.sv
src/fetch_fifo.sv
src/if_id_reg.sv
src/if_stage.sv
test/tb_if_stage.sv

/* Bender.yml */
package:
  name: if_stage

sources:
  - files:
      - src/if_pkg.sv
      - src/pc_select.sv
      - src/fetch_ctrl.sv
      - src/fetch_fifo.sv
      - src/if_id_reg.sv
      - src/if_stage.sv
  - target: test
    files:
      - test/tb_if_stage.sv
